// File: rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // funct7 patterns used by the OP and OP_IMM groups
  localparam logic [6:0] f7_base   = 7'b0000000;
  localparam logic [6:0] f7_alt    = 7'b0100000;  // SUB, SRA, SRAI
  localparam logic [6:0] f7_muldiv = 7'b0000001;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    EQ  = 3'b000,
    NE  = 3'b001,
    LT  = 3'b100,
    GE  = 3'b101,
    LTU = 3'b110,
    GEU = 3'b111
  } branch_f3_t;

  typedef enum logic [2:0] {
    ADD  = 3'b000,  // Also SUB with f7_alt
    SLL  = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SRL  = 3'b101,  // Also SRA with f7_alt
    OR   = 3'b110,
    AND  = 3'b111
  } arith_f3_t;

  // Upper half of the funct3 space is DIV/REM, not decoded
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011
  } mul_f3_t;

  typedef enum logic [2:0] {
    R,
    I,
    S,
    B,
    U,
    J,
    NONE
  } instr_type_t;

endpackage

// File: core_ctrl_pkg.sv
package core_ctrl_pkg;

  // Encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    DB = 2'b00,
    DH = 2'b01,
    DW = 2'b10
  } data_width_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_MUL,
    ALU_MULH,
    ALU_MULHSU,
    ALU_MULHU,
    ALU_PASS_B  // LUI
  } alu_op_t;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_t;

  typedef struct packed {
    logic        s;         // Store
    logic        l;         // Load
    logic        w;         // Register write
    logic        b;         // Conditional branch
    logic        j;         // JAL or JALR
    logic        m;         // Multiply group
    logic        sign;      // Signed load
    data_width_t dw;        // Access width
    logic        op_b_imm;  // Operand B from immediate
  } control_signals_t;

endpackage

// File: ir_dec_ctrl.sv
`timescale 1ns/1ps

module ir_dec_ctrl #(
  parameter int IR_WIDTH = 32
) (
  input  logic [IR_WIDTH-1:0]               ir,
  output core_ctrl_pkg::control_signals_t   cs,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  output core_ctrl_pkg::op_a_sel_t          op_a_sel,
  output core_ctrl_pkg::alu_op_t            alu_op,
  output logic [IR_WIDTH-1:0]               imm,
  output logic [2:0]                        func3
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic [6:0]  func7;
  logic [6:0]  opcode;
  logic        op_imm_ok;
  logic        op_ok;
  logic        mul_ok;
  instr_type_t fmt;

  assign opcode = ir[6:0];
  assign func3  = ir[14:12];
  assign func7  = ir[31:25];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign rd     = ir[11:7];

  function automatic logic [IR_WIDTH-1:0] imm_of(instr_type_t t, logic [IR_WIDTH-1:0] w);
    logic [31:0] v;
    case (t)
      I:       v = {{20{w[31]}}, w[31:20]};
      S:       v = {{20{w[31]}}, w[31:25], w[11:7]};
      B:       v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      U:       v = {w[31:12], 12'b0};
      J:       v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: v = '0;  // R and NONE
    endcase
    return IR_WIDTH'(v);
  endfunction

  // OP and OP_IMM share this funct3 space
  function automatic alu_op_t arith_op(logic [2:0] f3, logic alt, logic reg_form);
    case (arith_f3_t'(f3))
      ADD:     return (alt && reg_form) ? ALU_SUB : ALU_ADD;  // ADDI never subtracts
      SLL:     return ALU_SLL;
      SLT:     return ALU_SLT;
      SLTU:    return ALU_SLTU;
      XOR:     return ALU_XOR;
      SRL:     return alt ? ALU_SRA : ALU_SRL;
      OR:      return ALU_OR;
      AND:     return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  function automatic alu_op_t mul_op(logic [2:0] f3);
    case (mul_f3_t'(f3))
      MUL:     return ALU_MUL;
      MULH:    return ALU_MULH;
      MULHSU:  return ALU_MULHSU;
      default: return ALU_MULHU;
    endcase
  endfunction

  // Shift immediates carry a funct7 that must be legal
  assign op_imm_ok = (func3 == SLL) ? (func7 == f7_base) :
                     (func3 == SRL) ? (func7 == f7_base || func7 == f7_alt) : 1'b1;
  assign op_ok     = (func7 == f7_base) ||
                     (func7 == f7_alt && (func3 == ADD || func3 == SRL));
  assign mul_ok    = (func7 == f7_muldiv) && !func3[2];  // DIV/REM fall to NOP

  always_comb begin
    cs       = '0;
    cs.dw    = DW;
    alu_op   = ALU_ADD;
    op_a_sel = OP_A_ZERO;
    fmt      = NONE;
    case (opcode)
      LUI: begin
        cs.w        = 1'b1;
        cs.op_b_imm = 1'b1;
        alu_op      = ALU_PASS_B;
        fmt         = U;
      end
      AUIPC: begin
        cs.w        = 1'b1;
        cs.op_b_imm = 1'b1;
        op_a_sel    = OP_A_PC;
        fmt         = U;
      end
      JAL: begin
        cs.w        = 1'b1;
        cs.j        = 1'b1;
        cs.op_b_imm = 1'b1;
        op_a_sel    = OP_A_PC;  // Sum equals the jump target
        fmt         = J;
      end
      JALR: begin
        cs.w        = 1'b1;
        cs.j        = 1'b1;
        cs.op_b_imm = 1'b1;
        op_a_sel    = OP_A_REG;
        fmt         = I;
      end
      BRANCH: begin
        if (func3[2:1] != 2'b01) begin  // funct3 2 and 3 are reserved
          cs.b     = 1'b1;
          op_a_sel = OP_A_REG;
          alu_op   = ALU_SUB;
          fmt      = B;
        end
      end
      LOAD: begin
        if (func3[1:0] != 2'b11 && func3[2:1] != 2'b11) begin
          cs.l        = 1'b1;
          cs.w        = 1'b1;
          cs.sign     = !func3[2];
          cs.dw       = data_width_t'(func3[1:0]);
          cs.op_b_imm = 1'b1;
          op_a_sel    = OP_A_REG;
          fmt         = I;
        end
      end
      STORE: begin
        if (!func3[2] && func3[1:0] != 2'b11) begin
          cs.s        = 1'b1;
          cs.dw       = data_width_t'(func3[1:0]);
          cs.op_b_imm = 1'b1;
          op_a_sel    = OP_A_REG;
          fmt         = S;
        end
      end
      OP_IMM: begin
        if (op_imm_ok) begin
          cs.w        = 1'b1;
          cs.op_b_imm = 1'b1;
          op_a_sel    = OP_A_REG;
          alu_op      = arith_op(func3, func7[5], 1'b0);
          fmt         = I;
        end
      end
      OP: begin
        if (mul_ok) begin
          cs.w     = 1'b1;
          cs.m     = 1'b1;
          op_a_sel = OP_A_REG;
          alu_op   = mul_op(func3);
          fmt      = R;
        end else if (op_ok) begin
          cs.w     = 1'b1;
          op_a_sel = OP_A_REG;
          alu_op   = arith_op(func3, func7[5], 1'b1);
          fmt      = R;
        end
      end
      default: ;  // Unknown encoding, all flags low
    endcase
  end

  assign imm = imm_of(fmt, ir);

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [rv_isa_pkg::xlen-1:0] a,
  input  logic [rv_isa_pkg::xlen-1:0] b,
  input  core_ctrl_pkg::alu_op_t      alu_op,
  input  logic [2:0]                  func3,
  output logic [rv_isa_pkg::xlen-1:0] result,
  output logic                        branch_cond
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic [$clog2(xlen)-1:0] shamt;
  logic [2*xlen-1:0]       prod_ss;
  logic [2*xlen-1:0]       prod_su;
  logic [2*xlen-1:0]       prod_uu;

  assign shamt = b[$clog2(xlen)-1:0];

  // Extending to 2*xlen first keeps the full product in the low bits
  assign prod_uu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
  assign prod_ss = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};
  assign prod_su = {{xlen{a[xlen-1]}}, a} * {{xlen{1'b0}}, b};

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {{(xlen-1){1'b0}}, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_MUL:    result = prod_uu[xlen-1:0];  // Low half is sign agnostic
      ALU_MULH:   result = prod_ss[2*xlen-1:xlen];
      ALU_MULHSU: result = prod_su[2*xlen-1:xlen];
      ALU_MULHU:  result = prod_uu[2*xlen-1:xlen];
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch compare runs in parallel with the result mux
  always_comb begin
    case (func3)
      EQ:      branch_cond = (a == b);
      NE:      branch_cond = (a != b);
      LT:      branch_cond = ($signed(a) < $signed(b));
      GE:      branch_cond = ($signed(a) >= $signed(b));
      LTU:     branch_cond = (a < b);
      GEU:     branch_cond = (a >= b);
      default: branch_cond = 1'b0;
    endcase
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  input  logic                            we,
  input  logic [rv_isa_pkg::xlen-1:0]       wd,
  output logic [rv_isa_pkg::xlen-1:0]       rd1,
  output logic [rv_isa_pkg::xlen-1:0]       rd2
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 is never written
      regs[rd] <= wd;
    end
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic [rv_isa_pkg::xlen-1:0]       instr,
  input  logic [rv_isa_pkg::xlen-1:0]       pc,
  output logic                              ack,
  output logic                              wb_en,
  output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_isa_pkg::xlen-1:0]       wb_data,
  output logic                              branch_taken,
  output logic [rv_isa_pkg::xlen-1:0]       next_pc,
  output logic                              mem_load,
  output logic                              mem_store,
  output core_ctrl_pkg::data_width_t        mem_size,
  output logic [rv_isa_pkg::xlen-1:0]       mem_addr
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_DONE} state_t;

  state_t                state;
  logic [xlen-1:0]       ir_q;
  logic [xlen-1:0]       pc_q;
  control_signals_t      cs;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  op_a_sel_t             op_a_sel;
  alu_op_t               alu_op;
  logic [xlen-1:0]       imm;
  logic [2:0]            func3;
  logic [xlen-1:0]       rd1;
  logic [xlen-1:0]       rd2;
  logic [xlen-1:0]       op_a;
  logic [xlen-1:0]       op_b;
  logic [xlen-1:0]       alu_result;
  logic                  branch_cond;
  logic                  taken;
  logic                  rf_we;
  logic [xlen-1:0]       pc_plus_4;
  logic [xlen-1:0]       target;
  logic [xlen-1:0]       wb_value;

  ir_dec_ctrl #(.IR_WIDTH(xlen)) u_dec (
    .ir       (ir_q),
    .cs       (cs),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .op_a_sel (op_a_sel),
    .alu_op   (alu_op),
    .imm      (imm),
    .func3    (func3)
  );

  reg_file u_rf (
    .clk   (clk),
    .reset (reset),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .we    (rf_we),
    .wd    (wb_value),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  alu u_alu (
    .a           (op_a),
    .b           (op_b),
    .alu_op      (alu_op),
    .func3       (func3),
    .result      (alu_result),
    .branch_cond (branch_cond)
  );

  always_comb begin
    case (op_a_sel)
      OP_A_PC:   op_a = pc_q;
      OP_A_ZERO: op_a = '0;
      default:   op_a = rd1;
    endcase
  end

  assign op_b = cs.op_b_imm ? imm : rd2;

  assign pc_plus_4 = pc_q + xlen'(4);
  assign taken     = cs.j || (cs.b && branch_cond);

  always_comb begin
    if (cs.j && ir_q[6:0] == JALR) begin
      target = {alu_result[xlen-1:1], 1'b0};  // JALR clears bit 0
    end else if (taken) begin
      target = pc_q + imm;
    end else begin
      target = pc_plus_4;
    end
  end

  assign wb_value = cs.j ? pc_plus_4 : alu_result;  // Link address for jumps
  assign rf_we    = (state == ST_EXEC) && cs.w && !cs.l;  // No data memory behind loads

  // Four-phase handshake, one instruction in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      ack          <= 1'b0;
      wb_en        <= 1'b0;
      branch_taken <= 1'b0;
      mem_load     <= 1'b0;
      mem_store    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          state        <= ST_DONE;
          ack          <= 1'b1;
          wb_en        <= rf_we;
          branch_taken <= taken;
          mem_load     <= cs.l;
          mem_store    <= cs.s;
        end
        ST_DONE: begin
          if (!req) begin  // Held req stalls here
            state <= ST_IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      ir_q <= instr;
      pc_q <= pc;
    end
    if (state == ST_EXEC) begin
      wb_rd    <= rd;
      wb_data  <= wb_value;
      next_pc  <= target;
      mem_size <= cs.dw;
      mem_addr <= alu_result;  // rs1 plus imm for loads and stores
    end
  end

endmodule

// File: exec_unit_properties.sv
`timescale 1ns/1ps

module exec_unit_properties (
  input logic                              clk,
  input logic                              reset,
  input logic                              req,
  input logic                              ack,
  input logic                              wb_en,
  input logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
  input logic [rv_isa_pkg::xlen-1:0]       wb_data,
  input logic                              branch_taken,
  input logic [rv_isa_pkg::xlen-1:0]       next_pc,
  input logic                              mem_load,
  input logic                              mem_store,
  input core_ctrl_pkg::data_width_t        mem_size,
  input logic [rv_isa_pkg::xlen-1:0]       mem_addr
);

  // Rising ack needs req high on the edge that set it
  assert property (@(posedge clk) disable iff (reset)
    ack && !$past(ack) |-> $past(req))
    else $error("ack rose without req");

  assert property (@(posedge clk) disable iff (reset)
    $past(req, 2) && !$past(req, 3) && !$past(ack, 2) |-> ack && !$past(ack))
    else $error("ack did not rise two edges after req");

  assert property (@(posedge clk) disable iff (reset)
    $past(req, 2) && !$past(req) |-> $past(ack) && !ack)
    else $error("ack did not fall one edge after req");

  assert property (@(posedge clk) disable iff (reset)
    ack && $past(ack) |-> $stable(wb_en) && $stable(wb_rd) && $stable(wb_data) &&
      $stable(branch_taken) && $stable(next_pc) && $stable(mem_load) &&
      $stable(mem_store) && $stable(mem_size) && $stable(mem_addr))
    else $error("results changed while ack was high");

  assert property (@(posedge clk) reset && $past(reset) |-> !ack)
    else $error("ack high during reset");

endmodule

bind exec_unit exec_unit_properties u_props (
  .clk          (clk),
  .reset        (reset),
  .req          (req),
  .ack          (ack),
  .wb_en        (wb_en),
  .wb_rd        (wb_rd),
  .wb_data      (wb_data),
  .branch_taken (branch_taken),
  .next_pc      (next_pc),
  .mem_load     (mem_load),
  .mem_store    (mem_store),
  .mem_size     (mem_size),
  .mem_addr     (mem_addr)
);

// File: exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;
  import core_ctrl_pkg::*;

  localparam int timeout_cycles = 20;
  localparam int hold_cycles    = 4;  // Extra req cycles in group 6

  logic        clk;
  logic        reset;
  logic        req;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        ack;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        branch_taken;
  logic [31:0] next_pc;
  logic        mem_load;
  logic        mem_store;
  data_width_t mem_size;
  logic [31:0] mem_addr;

  // Fields of the current line in exec_cases.txt
  logic [31:0] e_grp;
  logic [31:0] e_instr;
  logic [31:0] e_pc;
  logic [31:0] e_wb_en;
  logic [31:0] e_wb_rd;
  logic [31:0] e_wb_data;
  logic [31:0] e_taken;
  logic [31:0] e_next_pc;
  logic [31:0] e_load;
  logic [31:0] e_store;
  logic [31:0] e_size;
  logic [31:0] e_addr;

  logic [31:0] cur_group;
  int          group_errors;
  int          group_cases;
  int          pass_groups;
  int          fail_groups;
  bit          timed_out;

  exec_unit dut0 (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .instr        (instr),
    .pc           (pc),
    .ack          (ack),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .branch_taken (branch_taken),
    .next_pc      (next_pc),
    .mem_load     (mem_load),
    .mem_store    (mem_store),
    .mem_size     (mem_size),
    .mem_addr     (mem_addr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h (instr 0x%h)",
               name, got, exp, e_instr);
      group_errors++;
    end
  endtask

  task automatic check_outputs();
    check_value("wb_en", 32'(wb_en), e_wb_en);
    if (e_wb_en[0]) begin  // rd and data only matter on a write
      check_value("wb_rd", 32'(wb_rd), e_wb_rd);
      check_value("wb_data", wb_data, e_wb_data);
    end
    check_value("branch_taken", 32'(branch_taken), e_taken);
    check_value("next_pc", next_pc, e_next_pc);
    check_value("mem_load", 32'(mem_load), e_load);
    check_value("mem_store", 32'(mem_store), e_store);
    if (e_load[0] || e_store[0]) begin
      check_value("mem_size", 32'(mem_size), e_size);
      check_value("mem_addr", mem_addr, e_addr);
    end
  endtask

  // Samples ack half a step after each edge, where it is settled
  task automatic wait_ack(input logic level, output int cycles, output bit ok);
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < timeout_cycles) begin
      @(posedge clk);
      #0.5;
      cycles++;
      if (ack === level) ok = 1'b1;
    end
  endtask

  task automatic finish_group();
    if (group_errors == 0) begin
      pass_groups++;
      $display("group %0d passed, %0d cases", cur_group, group_cases);
    end else begin
      fail_groups++;
      $display("group %0d FAILED, %0d errors", cur_group, group_errors);
    end
    group_errors = 0;
    group_cases  = 0;
  endtask

  task automatic run_case();
    int cycles;
    bit ok;
    if (e_grp != cur_group) begin
      if (cur_group != 0) finish_group();
      cur_group = e_grp;
    end
    assert (ack === 1'b0) else begin
      $display("ack was already high before req for instr 0x%h", e_instr);
      group_errors++;
    end
    instr = e_instr;
    pc    = e_pc;
    req   = 1'b1;
    wait_ack(1'b1, cycles, ok);
    if (!ok) begin
      $display("Timeout: ack never rose for instr 0x%h", e_instr);
      group_errors++;
      timed_out = 1'b1;
    end else begin
      check_value("ack latency", 32'(cycles), 32'd2);
      check_outputs();
      if (e_grp == 6) begin
        repeat (hold_cycles) begin  // Held req must not disturb the results
          @(posedge clk);
          #0.5;
          check_value("ack", 32'(ack), 32'd1);
          check_outputs();
        end
      end
      req = 1'b0;
      wait_ack(1'b0, cycles, ok);
      if (!ok) begin
        $display("Timeout: ack never fell after req dropped, instr 0x%h", e_instr);
        group_errors++;
        timed_out = 1'b1;
      end else begin
        group_cases++;
      end
    end
  endtask

  initial begin
    int    fd;
    int    n;
    string line;
    reset        = 1'b1;
    req          = 1'b0;
    instr        = '0;
    pc           = '0;
    cur_group    = '0;
    group_errors = 0;
    group_cases  = 0;
    pass_groups  = 0;
    fail_groups  = 0;
    timed_out    = 1'b0;
    e_instr      = '0;
    repeat (4) @(posedge clk);
    #0.5;
    reset = 1'b0;
    check_value("ack", 32'(ack), 32'd0);  // Counted with group 1
    check_value("wb_en", 32'(wb_en), 32'd0);
    check_value("branch_taken", 32'(branch_taken), 32'd0);
    check_value("mem_load", 32'(mem_load), 32'd0);
    check_value("mem_store", 32'(mem_store), 32'd0);
    fd = $fopen("exec_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open exec_cases.txt");
      fail_groups++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", e_grp, e_instr,
                    e_pc, e_wb_en, e_wb_rd, e_wb_data, e_taken, e_next_pc, e_load,
                    e_store, e_size, e_addr) == 12) begin
          run_case();
        end
      end
      $fclose(fd);
      if (cur_group != 0) finish_group();
    end
    $display("groups passed: %0d, groups failed: %0d", pass_groups, fail_groups);
    if (fail_groups == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: exec_cases.txt
# group instr pc wb_en wb_rd wb_data taken next_pc load store size addr, all hex
# Register state carries over from line to line
1 002081B3 00000100 1 03 00000000 0 00000104 0 0 0 00000000
2 00500093 00000200 1 01 00000005 0 00000204 0 0 0 00000000
2 FFD00113 00000204 1 02 FFFFFFFD 0 00000208 0 0 0 00000000
2 12345237 00000208 1 04 12345000 0 0000020C 0 0 0 00000000
2 00001297 0000020C 1 05 0000120C 0 00000210 0 0 0 00000000
2 00208333 00000210 1 06 00000002 0 00000214 0 0 0 00000000
2 402083B3 00000214 1 07 00000008 0 00000218 0 0 0 00000000
2 00112433 00000218 1 08 00000001 0 0000021C 0 0 0 00000000
2 001134B3 0000021C 1 09 00000000 0 00000220 0 0 0 00000000
2 00109533 00000220 1 0A 000000A0 0 00000224 0 0 0 00000000
2 401155B3 00000224 1 0B FFFFFFFF 0 00000228 0 0 0 00000000
2 00115633 00000228 1 0C 07FFFFFF 0 0000022C 0 0 0 00000000
2 0020C6B3 0000022C 1 0D FFFFFFF8 0 00000230 0 0 0 00000000
2 0020E733 00000230 1 0E FFFFFFFD 0 00000234 0 0 0 00000000
2 0020F7B3 00000234 1 0F 00000005 0 00000238 0 0 0 00000000
2 00700013 00000238 1 00 00000007 0 0000023C 0 0 0 00000000
2 00000833 0000023C 1 10 00000000 0 00000240 0 0 0 00000000
3 02110933 00000300 1 12 FFFFFFF1 0 00000304 0 0 0 00000000
3 021119B3 00000304 1 13 FFFFFFFF 0 00000308 0 0 0 00000000
3 0220AA33 00000308 1 14 00000004 0 0000030C 0 0 0 00000000
3 02213AB3 0000030C 1 15 FFFFFFFA 0 00000310 0 0 0 00000000
3 02211B33 00000310 1 16 00000000 0 00000314 0 0 0 00000000
4 00108863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 00208863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 00209863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 00109863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 00114863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 0020C863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 0020D863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 00115863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 0020E863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 00116863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 00117863 00000400 0 00 00000000 1 00000410 0 0 0 00000000
4 0020F863 00000400 0 00 00000000 0 00000404 0 0 0 00000000
4 02000BEF 00000500 1 17 00000504 1 00000520 0 0 0 00000000
4 00408C67 00000600 1 18 00000604 1 00000008 0 0 0 00000000
5 00822C83 00000700 0 00 00000000 0 00000704 1 0 2 12345008
5 FFF20D03 00000704 0 00 00000000 0 00000708 1 0 0 12344FFF
5 00225D83 00000708 0 00 00000000 0 0000070C 1 0 1 12345002
5 00122623 0000070C 0 00 00000000 0 00000710 0 1 2 1234500C
5 FE220E23 00000710 0 00 00000000 0 00000714 0 1 0 12344FFC
5 00121323 00000714 0 00 00000000 0 00000718 0 1 1 12345006
5 000C8E33 00000718 1 1C 00000000 0 0000071C 0 0 0 00000000
5 0220CEB3 0000071C 0 00 00000000 0 00000720 0 0 0 00000000
6 001F0F13 00000800 1 1E 00000001 0 00000804 0 0 0 00000000
6 000F0FB3 00000804 1 1F 00000001 0 00000808 0 0 0 00000000

// File: compile.f
rv_isa_pkg.sv
core_ctrl_pkg.sv
ir_dec_ctrl.sv
alu.sv
reg_file.sv
exec_unit.sv
exec_unit_properties.sv
exec_unit_tb.sv

// File: Makefile
TOP     ?= exec_unit_tb
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all build run lint clean

all: run

build:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)
